// ==== source/rv_dec_pkg.sv ====
/*
  shared definitions for the RV32IM decoder
  - word, register index and CSR address widths
  - function code and immediate kind enumerations
  - mask/match pair per instruction and the ordered lookup tables
  - instruction word union with R-type and S/B immediate views
*/

`default_nettype none

package rv_dec_pkg;

  localparam int XLEN  = 32;
  localparam int REG_W = 5;
  localparam int CSR_W = 12;

  // number of table entries, ILLEGAL excluded
  localparam int N_FUNC = 56;

  // table index order, later entries win on overlap
  typedef enum logic [6:0] {
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    FENCE, FENCE_TSO, PAUSE, ECALL, EBREAK,
    CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    ILLEGAL = 7'h7F
  } func_e;

  typedef enum logic [2:0] {
    NONE, I, S, B, U, J, C
  } imm_kind_e;

  ////////////////////
  // mask / match pairs
  ////////////////////

  localparam logic [XLEN-1:0] LUI_MASK    = 32'h0000_007F, LUI_MATCH    = 32'h0000_0037;
  localparam logic [XLEN-1:0] AUIPC_MASK  = 32'h0000_007F, AUIPC_MATCH  = 32'h0000_0017;
  localparam logic [XLEN-1:0] JAL_MASK    = 32'h0000_007F, JAL_MATCH    = 32'h0000_006F;
  localparam logic [XLEN-1:0] JALR_MASK   = 32'h0000_707F, JALR_MATCH   = 32'h0000_0067;
  localparam logic [XLEN-1:0] BEQ_MASK    = 32'h0000_707F, BEQ_MATCH    = 32'h0000_0063;
  localparam logic [XLEN-1:0] BNE_MASK    = 32'h0000_707F, BNE_MATCH    = 32'h0000_1063;
  localparam logic [XLEN-1:0] BLT_MASK    = 32'h0000_707F, BLT_MATCH    = 32'h0000_4063;
  localparam logic [XLEN-1:0] BGE_MASK    = 32'h0000_707F, BGE_MATCH    = 32'h0000_5063;
  localparam logic [XLEN-1:0] BLTU_MASK   = 32'h0000_707F, BLTU_MATCH   = 32'h0000_6063;
  localparam logic [XLEN-1:0] BGEU_MASK   = 32'h0000_707F, BGEU_MATCH   = 32'h0000_7063;
  localparam logic [XLEN-1:0] LB_MASK     = 32'h0000_707F, LB_MATCH     = 32'h0000_0003;
  localparam logic [XLEN-1:0] LH_MASK     = 32'h0000_707F, LH_MATCH     = 32'h0000_1003;
  localparam logic [XLEN-1:0] LW_MASK     = 32'h0000_707F, LW_MATCH     = 32'h0000_2003;
  localparam logic [XLEN-1:0] LBU_MASK    = 32'h0000_707F, LBU_MATCH    = 32'h0000_4003;
  localparam logic [XLEN-1:0] LHU_MASK    = 32'h0000_707F, LHU_MATCH    = 32'h0000_5003;
  localparam logic [XLEN-1:0] SB_MASK     = 32'h0000_707F, SB_MATCH     = 32'h0000_0023;
  localparam logic [XLEN-1:0] SH_MASK     = 32'h0000_707F, SH_MATCH     = 32'h0000_1023;
  localparam logic [XLEN-1:0] SW_MASK     = 32'h0000_707F, SW_MATCH     = 32'h0000_2023;
  localparam logic [XLEN-1:0] ADDI_MASK   = 32'h0000_707F, ADDI_MATCH   = 32'h0000_0013;
  localparam logic [XLEN-1:0] SLTI_MASK   = 32'h0000_707F, SLTI_MATCH   = 32'h0000_2013;
  localparam logic [XLEN-1:0] SLTIU_MASK  = 32'h0000_707F, SLTIU_MATCH  = 32'h0000_3013;
  localparam logic [XLEN-1:0] XORI_MASK   = 32'h0000_707F, XORI_MATCH   = 32'h0000_4013;
  localparam logic [XLEN-1:0] ORI_MASK    = 32'h0000_707F, ORI_MATCH    = 32'h0000_6013;
  localparam logic [XLEN-1:0] ANDI_MASK   = 32'h0000_707F, ANDI_MATCH   = 32'h0000_7013;
  localparam logic [XLEN-1:0] SLLI_MASK   = 32'hFE00_707F, SLLI_MATCH   = 32'h0000_1013;
  localparam logic [XLEN-1:0] SRLI_MASK   = 32'hFE00_707F, SRLI_MATCH   = 32'h0000_5013;
  localparam logic [XLEN-1:0] SRAI_MASK   = 32'hFE00_707F, SRAI_MATCH   = 32'h4000_5013;
  localparam logic [XLEN-1:0] ADD_MASK    = 32'hFE00_707F, ADD_MATCH    = 32'h0000_0033;
  localparam logic [XLEN-1:0] SUB_MASK    = 32'hFE00_707F, SUB_MATCH    = 32'h4000_0033;
  localparam logic [XLEN-1:0] SLL_MASK    = 32'hFE00_707F, SLL_MATCH    = 32'h0000_1033;
  localparam logic [XLEN-1:0] SLT_MASK    = 32'hFE00_707F, SLT_MATCH    = 32'h0000_2033;
  localparam logic [XLEN-1:0] SLTU_MASK   = 32'hFE00_707F, SLTU_MATCH   = 32'h0000_3033;
  localparam logic [XLEN-1:0] XOR_MASK    = 32'hFE00_707F, XOR_MATCH    = 32'h0000_4033;
  localparam logic [XLEN-1:0] SRL_MASK    = 32'hFE00_707F, SRL_MATCH    = 32'h0000_5033;
  localparam logic [XLEN-1:0] SRA_MASK    = 32'hFE00_707F, SRA_MATCH    = 32'h4000_5033;
  localparam logic [XLEN-1:0] OR_MASK     = 32'hFE00_707F, OR_MATCH     = 32'h0000_6033;
  localparam logic [XLEN-1:0] AND_MASK    = 32'hFE00_707F, AND_MATCH    = 32'h0000_7033;
  localparam logic [XLEN-1:0] FENCE_MASK  = 32'h0000_707F, FENCE_MATCH  = 32'h0000_000F;
  localparam logic [XLEN-1:0] FENCE_TSO_MASK = 32'hFFFF_FFFF, FENCE_TSO_MATCH = 32'h8330_000F;
  localparam logic [XLEN-1:0] PAUSE_MASK  = 32'hFFFF_FFFF, PAUSE_MATCH  = 32'h0100_000F;
  localparam logic [XLEN-1:0] ECALL_MASK  = 32'hFFFF_FFFF, ECALL_MATCH  = 32'h0000_0073;
  localparam logic [XLEN-1:0] EBREAK_MASK = 32'hFFFF_FFFF, EBREAK_MATCH = 32'h0010_0073;
  localparam logic [XLEN-1:0] CSRRW_MASK  = 32'h0000_707F, CSRRW_MATCH  = 32'h0000_1073;
  localparam logic [XLEN-1:0] CSRRS_MASK  = 32'h0000_707F, CSRRS_MATCH  = 32'h0000_2073;
  localparam logic [XLEN-1:0] CSRRC_MASK  = 32'h0000_707F, CSRRC_MATCH  = 32'h0000_3073;
  localparam logic [XLEN-1:0] CSRRWI_MASK = 32'h0000_707F, CSRRWI_MATCH = 32'h0000_5073;
  localparam logic [XLEN-1:0] CSRRSI_MASK = 32'h0000_707F, CSRRSI_MATCH = 32'h0000_6073;
  localparam logic [XLEN-1:0] CSRRCI_MASK = 32'h0000_707F, CSRRCI_MATCH = 32'h0000_7073;
  localparam logic [XLEN-1:0] MUL_MASK    = 32'hFE00_707F, MUL_MATCH    = 32'h0200_0033;
  localparam logic [XLEN-1:0] MULH_MASK   = 32'hFE00_707F, MULH_MATCH   = 32'h0200_1033;
  localparam logic [XLEN-1:0] MULHSU_MASK = 32'hFE00_707F, MULHSU_MATCH = 32'h0200_2033;
  localparam logic [XLEN-1:0] MULHU_MASK  = 32'hFE00_707F, MULHU_MATCH  = 32'h0200_3033;
  localparam logic [XLEN-1:0] DIV_MASK    = 32'hFE00_707F, DIV_MATCH    = 32'h0200_4033;
  localparam logic [XLEN-1:0] DIVU_MASK   = 32'hFE00_707F, DIVU_MATCH   = 32'h0200_5033;
  localparam logic [XLEN-1:0] REM_MASK    = 32'hFE00_707F, REM_MATCH    = 32'h0200_6033;
  localparam logic [XLEN-1:0] REMU_MASK   = 32'hFE00_707F, REMU_MATCH   = 32'h0200_7033;

  // indexed by func_e code
  localparam logic [XLEN-1:0] MASK_TBL [N_FUNC] = '{
    LUI_MASK, AUIPC_MASK, JAL_MASK, JALR_MASK,
    BEQ_MASK, BNE_MASK, BLT_MASK, BGE_MASK, BLTU_MASK, BGEU_MASK,
    LB_MASK, LH_MASK, LW_MASK, LBU_MASK, LHU_MASK,
    SB_MASK, SH_MASK, SW_MASK,
    ADDI_MASK, SLTI_MASK, SLTIU_MASK, XORI_MASK, ORI_MASK, ANDI_MASK,
    SLLI_MASK, SRLI_MASK, SRAI_MASK,
    ADD_MASK, SUB_MASK, SLL_MASK, SLT_MASK, SLTU_MASK,
    XOR_MASK, SRL_MASK, SRA_MASK, OR_MASK, AND_MASK,
    FENCE_MASK, FENCE_TSO_MASK, PAUSE_MASK, ECALL_MASK, EBREAK_MASK,
    CSRRW_MASK, CSRRS_MASK, CSRRC_MASK, CSRRWI_MASK, CSRRSI_MASK, CSRRCI_MASK,
    MUL_MASK, MULH_MASK, MULHSU_MASK, MULHU_MASK,
    DIV_MASK, DIVU_MASK, REM_MASK, REMU_MASK
  };

  localparam logic [XLEN-1:0] MATCH_TBL [N_FUNC] = '{
    LUI_MATCH, AUIPC_MATCH, JAL_MATCH, JALR_MATCH,
    BEQ_MATCH, BNE_MATCH, BLT_MATCH, BGE_MATCH, BLTU_MATCH, BGEU_MATCH,
    LB_MATCH, LH_MATCH, LW_MATCH, LBU_MATCH, LHU_MATCH,
    SB_MATCH, SH_MATCH, SW_MATCH,
    ADDI_MATCH, SLTI_MATCH, SLTIU_MATCH, XORI_MATCH, ORI_MATCH, ANDI_MATCH,
    SLLI_MATCH, SRLI_MATCH, SRAI_MATCH,
    ADD_MATCH, SUB_MATCH, SLL_MATCH, SLT_MATCH, SLTU_MATCH,
    XOR_MATCH, SRL_MATCH, SRA_MATCH, OR_MATCH, AND_MATCH,
    FENCE_MATCH, FENCE_TSO_MATCH, PAUSE_MATCH, ECALL_MATCH, EBREAK_MATCH,
    CSRRW_MATCH, CSRRS_MATCH, CSRRC_MATCH, CSRRWI_MATCH, CSRRSI_MATCH, CSRRCI_MATCH,
    MUL_MATCH, MULH_MATCH, MULHSU_MATCH, MULHU_MATCH,
    DIV_MATCH, DIVU_MATCH, REM_MATCH, REMU_MATCH
  };

  ////////////////////
  // instruction word views
  ////////////////////

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } instr_u;

endpackage

`default_nettype wire

// ==== source/rv_instr_match.sv ====
/*
  instruction matcher
  - priority walk over the mask/match table
  - register use flags and immediate kind per function
  - unmatched words decode to ILLEGAL
*/

`timescale 1ns/1ns
`default_nettype none

module rv_instr_match (
  input  logic [rv_dec_pkg::XLEN-1:0] code_i,
  output rv_dec_pkg::func_e           func_o,
  output logic                        use_rd_o,
  output logic                        use_rs1_o,
  output logic                        use_rs2_o,
  output rv_dec_pkg::imm_kind_e       imm_kind_o
);

  rv_dec_pkg::func_e func;

  ////////////////////
  // function lookup
  ////////////////////

  // fence_tso and pause sit after fence so the exact encodings win
  always_comb begin
    func = rv_dec_pkg::ILLEGAL;
    for (int k = 0; k < rv_dec_pkg::N_FUNC; k++) begin
      if ((code_i & rv_dec_pkg::MASK_TBL[k]) == rv_dec_pkg::MATCH_TBL[k]) begin
        func = rv_dec_pkg::func_e'(k[6:0]);
      end
    end
  end

  assign func_o = func;

  ////////////////////
  // attributes
  ////////////////////

  always_comb begin
    use_rd_o   = 1'b0;
    use_rs1_o  = 1'b0;
    use_rs2_o  = 1'b0;
    imm_kind_o = rv_dec_pkg::NONE;
    case (func)
      rv_dec_pkg::LUI, rv_dec_pkg::AUIPC: begin
        use_rd_o   = 1'b1;
        imm_kind_o = rv_dec_pkg::U;
      end
      rv_dec_pkg::JAL: begin
        use_rd_o   = 1'b1;
        imm_kind_o = rv_dec_pkg::J;
      end
      rv_dec_pkg::JALR,
      rv_dec_pkg::LB, rv_dec_pkg::LH, rv_dec_pkg::LW, rv_dec_pkg::LBU, rv_dec_pkg::LHU,
      rv_dec_pkg::ADDI, rv_dec_pkg::SLTI, rv_dec_pkg::SLTIU,
      rv_dec_pkg::XORI, rv_dec_pkg::ORI, rv_dec_pkg::ANDI,
      rv_dec_pkg::SLLI, rv_dec_pkg::SRLI, rv_dec_pkg::SRAI: begin
        use_rd_o   = 1'b1;
        use_rs1_o  = 1'b1;
        imm_kind_o = rv_dec_pkg::I;
      end
      rv_dec_pkg::BEQ, rv_dec_pkg::BNE, rv_dec_pkg::BLT,
      rv_dec_pkg::BGE, rv_dec_pkg::BLTU, rv_dec_pkg::BGEU: begin
        use_rs1_o  = 1'b1;
        use_rs2_o  = 1'b1;
        imm_kind_o = rv_dec_pkg::B;
      end
      rv_dec_pkg::SB, rv_dec_pkg::SH, rv_dec_pkg::SW: begin
        use_rs1_o  = 1'b1;
        use_rs2_o  = 1'b1;
        imm_kind_o = rv_dec_pkg::S;
      end
      // register-register ALU and M extension
      rv_dec_pkg::ADD, rv_dec_pkg::SUB, rv_dec_pkg::SLL, rv_dec_pkg::SLT,
      rv_dec_pkg::SLTU, rv_dec_pkg::XOR, rv_dec_pkg::SRL, rv_dec_pkg::SRA,
      rv_dec_pkg::OR, rv_dec_pkg::AND,
      rv_dec_pkg::MUL, rv_dec_pkg::MULH, rv_dec_pkg::MULHSU, rv_dec_pkg::MULHU,
      rv_dec_pkg::DIV, rv_dec_pkg::DIVU, rv_dec_pkg::REM, rv_dec_pkg::REMU: begin
        use_rd_o  = 1'b1;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
      end
      rv_dec_pkg::FENCE, rv_dec_pkg::FENCE_TSO: begin
        use_rd_o  = 1'b1;
        use_rs1_o = 1'b1;
      end
      rv_dec_pkg::CSRRW, rv_dec_pkg::CSRRS, rv_dec_pkg::CSRRC: begin
        use_rd_o  = 1'b1;
        use_rs1_o = 1'b1;
      end
      // rs1 field carries the zimm here
      rv_dec_pkg::CSRRWI, rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI: begin
        use_rd_o   = 1'b1;
        imm_kind_o = rv_dec_pkg::C;
      end
      // pause, ecall, ebreak and illegal words
      default: begin
        use_rd_o   = 1'b0;
        use_rs1_o  = 1'b0;
        use_rs2_o  = 1'b0;
        imm_kind_o = rv_dec_pkg::NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/rv_imm_extract.sv ====
/*
  immediate extractor
  - I, S, B, U and J formats, sign-extended from bit 31 where signed
  - zero-extended 5-bit CSR immediate
*/

`timescale 1ns/1ns
`default_nettype none

module rv_imm_extract (
  input  rv_dec_pkg::instr_u          code_i,
  output logic [rv_dec_pkg::XLEN-1:0] i_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0] s_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0] b_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0] u_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0] j_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0] c_imm_o
);

  logic sign;

  // bit 31 of the word
  assign sign = code_i.r.funct7[6];

  // bits 31:20
  assign i_imm_o = {{(rv_dec_pkg::XLEN-12){sign}}, code_i.r.funct7, code_i.r.rs2};

  assign s_imm_o = {{(rv_dec_pkg::XLEN-12){sign}}, code_i.s.imm_hi, code_i.s.imm_lo};

  // imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
  assign b_imm_o = {{(rv_dec_pkg::XLEN-12){sign}},
                    code_i.s.imm_lo[0],
                    code_i.s.imm_hi[5:0],
                    code_i.s.imm_lo[4:1],
                    1'b0};

  assign u_imm_o = {code_i.r.funct7, code_i.r.rs2, code_i.r.rs1, code_i.r.funct3, 12'h000};

  // imm[20|10:1|11|19:12] from bit 31 down
  assign j_imm_o = {{(rv_dec_pkg::XLEN-20){sign}},
                    code_i.r.rs1,
                    code_i.r.funct3,
                    code_i.r.rs2[0],
                    code_i.r.funct7[5:0],
                    code_i.r.rs2[4:1],
                    1'b0};

  assign c_imm_o = {{(rv_dec_pkg::XLEN-5){1'b0}}, code_i.r.rs1};

endmodule

`default_nettype wire

// ==== source/rv_dec_combine.sv ====
/*
  decode result stage
  - immediate select by kind
  - register index gating and CSR address qualify
  - output registers, loaded on valid_i
*/

`timescale 1ns/1ns
`default_nettype none

module rv_dec_combine (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         valid_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  code_i,
  input  rv_dec_pkg::func_e            func_i,
  input  logic                         use_rd_i,
  input  logic                         use_rs1_i,
  input  logic                         use_rs2_i,
  input  rv_dec_pkg::imm_kind_e        imm_kind_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  i_imm_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  s_imm_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  b_imm_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  u_imm_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  j_imm_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  c_imm_i,
  output logic                         valid_o,
  output rv_dec_pkg::func_e            func_o,
  output logic [rv_dec_pkg::REG_W-1:0] rd_o,
  output logic [rv_dec_pkg::REG_W-1:0] rs1_o,
  output logic [rv_dec_pkg::REG_W-1:0] rs2_o,
  output logic [rv_dec_pkg::XLEN-1:0]  imm_o,
  output logic [rv_dec_pkg::CSR_W-1:0] csr_o
);

  logic [rv_dec_pkg::XLEN-1:0]  imm_sel;
  logic [rv_dec_pkg::REG_W-1:0] rd_sel;
  logic [rv_dec_pkg::REG_W-1:0] rs1_sel;
  logic [rv_dec_pkg::REG_W-1:0] rs2_sel;
  logic [rv_dec_pkg::CSR_W-1:0] csr_sel;
  logic                         is_csr;

  always_comb begin
    case (imm_kind_i)
      rv_dec_pkg::I: imm_sel = i_imm_i;
      rv_dec_pkg::S: imm_sel = s_imm_i;
      rv_dec_pkg::B: imm_sel = b_imm_i;
      rv_dec_pkg::U: imm_sel = u_imm_i;
      rv_dec_pkg::J: imm_sel = j_imm_i;
      rv_dec_pkg::C: imm_sel = c_imm_i;
      default:       imm_sel = '0;
    endcase
  end

  // unused register fields read as x0
  assign rd_sel  = use_rd_i  ? code_i[11:7]  : '0;
  assign rs1_sel = use_rs1_i ? code_i[19:15] : '0;
  assign rs2_sel = use_rs2_i ? code_i[24:20] : '0;

  assign is_csr = func_i inside {rv_dec_pkg::CSRRW, rv_dec_pkg::CSRRS, rv_dec_pkg::CSRRC,
                                 rv_dec_pkg::CSRRWI, rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI};

  assign csr_sel = is_csr ? code_i[31:20] : '0;

  ////////////////////
  // output registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      func_o  <= rv_dec_pkg::func_e'(7'h00);
      rd_o    <= '0;
      rs1_o   <= '0;
      rs2_o   <= '0;
      imm_o   <= '0;
      csr_o   <= '0;
    end else begin
      valid_o <= valid_i;
      // fields hold between strobes
      if (valid_i) begin
        func_o <= func_i;
        rd_o   <= rd_sel;
        rs1_o  <= rs1_sel;
        rs2_o  <= rs2_sel;
        imm_o  <= imm_sel;
        csr_o  <= csr_sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rv_dec_top.sv ====
/*
  RV32IM decoder top level
  - matcher and immediate extractor side by side
  - one register stage, one cycle latency
*/

`timescale 1ns/1ns
`default_nettype none

module rv_dec_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         valid_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  code_i,
  output logic                         valid_o,
  output rv_dec_pkg::func_e            func_o,
  output logic [rv_dec_pkg::REG_W-1:0] rd_o,
  output logic [rv_dec_pkg::REG_W-1:0] rs1_o,
  output logic [rv_dec_pkg::REG_W-1:0] rs2_o,
  output logic [rv_dec_pkg::XLEN-1:0]  imm_o,
  output logic [rv_dec_pkg::CSR_W-1:0] csr_o
);

  rv_dec_pkg::func_e           func;
  logic                        use_rd;
  logic                        use_rs1;
  logic                        use_rs2;
  rv_dec_pkg::imm_kind_e       imm_kind;
  logic [rv_dec_pkg::XLEN-1:0] i_imm;
  logic [rv_dec_pkg::XLEN-1:0] s_imm;
  logic [rv_dec_pkg::XLEN-1:0] b_imm;
  logic [rv_dec_pkg::XLEN-1:0] u_imm;
  logic [rv_dec_pkg::XLEN-1:0] j_imm;
  logic [rv_dec_pkg::XLEN-1:0] c_imm;

  rv_instr_match match_i (
    .code_i     (code_i),
    .func_o     (func),
    .use_rd_o   (use_rd),
    .use_rs1_o  (use_rs1),
    .use_rs2_o  (use_rs2),
    .imm_kind_o (imm_kind)
  );

  rv_imm_extract extract_i (
    .code_i  (code_i),
    .i_imm_o (i_imm),
    .s_imm_o (s_imm),
    .b_imm_o (b_imm),
    .u_imm_o (u_imm),
    .j_imm_o (j_imm),
    .c_imm_o (c_imm)
  );

  rv_dec_combine combine_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .code_i     (code_i),
    .func_i     (func),
    .use_rd_i   (use_rd),
    .use_rs1_i  (use_rs1),
    .use_rs2_i  (use_rs2),
    .imm_kind_i (imm_kind),
    .i_imm_i    (i_imm),
    .s_imm_i    (s_imm),
    .b_imm_i    (b_imm),
    .u_imm_i    (u_imm),
    .j_imm_i    (j_imm),
    .c_imm_i    (c_imm),
    .valid_o    (valid_o),
    .func_o     (func_o),
    .rd_o       (rd_o),
    .rs1_o      (rs1_o),
    .rs2_o      (rs2_o),
    .imm_o      (imm_o),
    .csr_o      (csr_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
/*
  testbench clock source
  - free running clock, 8 ns period
*/

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk_o
);

  localparam int HALF_NS = 4;

  initial clk_o = 1'b0;

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tb/rv_dec_chk.sv ====
/*
  decoder protocol checks, bound into rv_dec_top
  - one cycle latency of valid_o, including back-to-back words
  - illegal words carry no registers, immediate or CSR address
  - csr_o zero outside the CSR functions
*/

`timescale 1ns/1ns
`default_nettype none

module rv_dec_chk (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         in_valid_i,
  input logic                         out_valid_i,
  input rv_dec_pkg::func_e            func_i,
  input logic [rv_dec_pkg::REG_W-1:0] rd_i,
  input logic [rv_dec_pkg::REG_W-1:0] rs1_i,
  input logic [rv_dec_pkg::REG_W-1:0] rs2_i,
  input logic [rv_dec_pkg::XLEN-1:0]  imm_i,
  input logic [rv_dec_pkg::CSR_W-1:0] csr_i
);

  latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_valid_i |=> out_valid_i)
    else $error("valid_o missing one cycle after valid_i");

  idle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !in_valid_i |=> !out_valid_i)
    else $error("valid_o raised with no word one cycle earlier");

  // nothing decoded from an unknown word
  illegal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_i && func_i == rv_dec_pkg::ILLEGAL) |->
      (rd_i == '0 && rs1_i == '0 && rs2_i == '0 && imm_i == '0 && csr_i == '0))
    else $error("illegal word produced nonzero fields");

  csr_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_i && !(func_i inside {rv_dec_pkg::CSRRW, rv_dec_pkg::CSRRS,
                                       rv_dec_pkg::CSRRC, rv_dec_pkg::CSRRWI,
                                       rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI}))
      |-> csr_i == '0)
    else $error("csr_o nonzero for a non-CSR function");

endmodule

bind rv_dec_top rv_dec_chk chk_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_valid_i  (valid_i),
  .out_valid_i (valid_o),
  .func_i      (func_o),
  .rd_i        (rd_o),
  .rs1_i       (rs1_o),
  .rs2_i       (rs2_o),
  .imm_i       (imm_o),
  .csr_i       (csr_o)
);

`default_nettype wire

// ==== tb/rv_dec_tb.sv ====
/*
  testbench for the RV32IM decoder
  - seeded random words, from table patterns, odd opcodes and raw noise
  - reference decode model written from the ISA encodings
  - expected results queued and compared one cycle later
  - watchdog on total run time
*/

`timescale 1ns/1ns
`default_nettype none

module rv_dec_tb;

  localparam int          N_WORDS    = 3000;
  localparam int          CLK_NS     = 8;
  localparam int          RST_CYCLES = 16;
  localparam int          TIMEOUT_NS = (N_WORDS + RST_CYCLES + 64) * CLK_NS;
  localparam logic [31:0] SEED       = 32'h04730797;

  // FP, atomic and RV64-only major opcodes
  localparam logic [6:0] ODD_OPS [8] = '{7'h07, 7'h27, 7'h43, 7'h47,
                                         7'h53, 7'h2F, 7'h1B, 7'h3B};

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic [31:0]       in_code;
  logic              out_valid;
  rv_dec_pkg::func_e out_func;
  logic [4:0]        out_rd;
  logic [4:0]        out_rs1;
  logic [4:0]        out_rs2;
  logic [31:0]       out_imm;
  logic [11:0]       out_csr;

  // words in flight and the last decoded result
  logic              valid_q [$];
  logic [31:0]       word_q [$];
  rv_dec_pkg::func_e exp_func;
  logic [4:0]        exp_rd;
  logic [4:0]        exp_rs1;
  logic [4:0]        exp_rs2;
  logic [31:0]       exp_imm;
  logic [11:0]       exp_csr;

  tb_clkgen clkgen_i (
    .clk_o (clk)
  );

  rv_dec_top dut_i (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .valid_i (in_valid),
    .code_i  (in_code),
    .valid_o (out_valid),
    .func_o  (out_func),
    .rd_o    (out_rd),
    .rs1_o   (out_rs1),
    .rs2_o   (out_rs2),
    .imm_o   (out_imm),
    .csr_o   (out_csr)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "decoder output check");
    end
  endtask

  function automatic void ref_decode(
    input  logic [31:0]       w,
    output rv_dec_pkg::func_e f,
    output logic [4:0]        rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [31:0]       imm,
    output logic [11:0]       csr
  );
    logic [2:0] f3;
    logic [6:0] f7;
    logic [2:0] use_v;
    f3 = w[14:12];
    f7 = w[31:25];
    f  = rv_dec_pkg::ILLEGAL;
    case (w[6:0])
      7'h37: f = rv_dec_pkg::LUI;
      7'h17: f = rv_dec_pkg::AUIPC;
      7'h6F: f = rv_dec_pkg::JAL;
      7'h67:
        if (f3 == 3'd0)
          f = rv_dec_pkg::JALR;
      7'h63:
        case (f3)
          3'd0: f = rv_dec_pkg::BEQ;
          3'd1: f = rv_dec_pkg::BNE;
          3'd4: f = rv_dec_pkg::BLT;
          3'd5: f = rv_dec_pkg::BGE;
          3'd6: f = rv_dec_pkg::BLTU;
          3'd7: f = rv_dec_pkg::BGEU;
          default: f = rv_dec_pkg::ILLEGAL;
        endcase
      // LD and LWU fall out as illegal
      7'h03:
        case (f3)
          3'd0: f = rv_dec_pkg::LB;
          3'd1: f = rv_dec_pkg::LH;
          3'd2: f = rv_dec_pkg::LW;
          3'd4: f = rv_dec_pkg::LBU;
          3'd5: f = rv_dec_pkg::LHU;
          default: f = rv_dec_pkg::ILLEGAL;
        endcase
      7'h23:
        case (f3)
          3'd0: f = rv_dec_pkg::SB;
          3'd1: f = rv_dec_pkg::SH;
          3'd2: f = rv_dec_pkg::SW;
          default: f = rv_dec_pkg::ILLEGAL;
        endcase
      7'h13:
        case (f3)
          3'd0: f = rv_dec_pkg::ADDI;
          3'd1: f = (f7 == 7'h00) ? rv_dec_pkg::SLLI : rv_dec_pkg::ILLEGAL;
          3'd2: f = rv_dec_pkg::SLTI;
          3'd3: f = rv_dec_pkg::SLTIU;
          3'd4: f = rv_dec_pkg::XORI;
          3'd5: f = (f7 == 7'h00) ? rv_dec_pkg::SRLI :
                    (f7 == 7'h20) ? rv_dec_pkg::SRAI : rv_dec_pkg::ILLEGAL;
          3'd6: f = rv_dec_pkg::ORI;
          3'd7: f = rv_dec_pkg::ANDI;
        endcase
      7'h33:
        if (f7 == 7'h01) begin
          case (f3)
            3'd0: f = rv_dec_pkg::MUL;
            3'd1: f = rv_dec_pkg::MULH;
            3'd2: f = rv_dec_pkg::MULHSU;
            3'd3: f = rv_dec_pkg::MULHU;
            3'd4: f = rv_dec_pkg::DIV;
            3'd5: f = rv_dec_pkg::DIVU;
            3'd6: f = rv_dec_pkg::REM;
            3'd7: f = rv_dec_pkg::REMU;
          endcase
        end else if (f7 == 7'h20) begin
          if (f3 == 3'd0)
            f = rv_dec_pkg::SUB;
          else if (f3 == 3'd5)
            f = rv_dec_pkg::SRA;
        end else if (f7 == 7'h00) begin
          case (f3)
            3'd0: f = rv_dec_pkg::ADD;
            3'd1: f = rv_dec_pkg::SLL;
            3'd2: f = rv_dec_pkg::SLT;
            3'd3: f = rv_dec_pkg::SLTU;
            3'd4: f = rv_dec_pkg::XOR;
            3'd5: f = rv_dec_pkg::SRL;
            3'd6: f = rv_dec_pkg::OR;
            3'd7: f = rv_dec_pkg::AND;
          endcase
        end
      7'h0F:
        if (w == 32'h8330_000F)
          f = rv_dec_pkg::FENCE_TSO;
        else if (w == 32'h0100_000F)
          f = rv_dec_pkg::PAUSE;
        else if (f3 == 3'd0)
          f = rv_dec_pkg::FENCE;
      7'h73:
        if (w == 32'h0000_0073)
          f = rv_dec_pkg::ECALL;
        else if (w == 32'h0010_0073)
          f = rv_dec_pkg::EBREAK;
        else
          case (f3)
            3'd1: f = rv_dec_pkg::CSRRW;
            3'd2: f = rv_dec_pkg::CSRRS;
            3'd3: f = rv_dec_pkg::CSRRC;
            3'd5: f = rv_dec_pkg::CSRRWI;
            3'd6: f = rv_dec_pkg::CSRRSI;
            3'd7: f = rv_dec_pkg::CSRRCI;
            default: f = rv_dec_pkg::ILLEGAL;
          endcase
      default: f = rv_dec_pkg::ILLEGAL;
    endcase

    // {rd, rs1, rs2} in use
    case (f)
      rv_dec_pkg::LUI, rv_dec_pkg::AUIPC, rv_dec_pkg::JAL,
      rv_dec_pkg::CSRRWI, rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI:
        use_v = 3'b100;
      rv_dec_pkg::JALR, rv_dec_pkg::LB, rv_dec_pkg::LH, rv_dec_pkg::LW,
      rv_dec_pkg::LBU, rv_dec_pkg::LHU, rv_dec_pkg::ADDI, rv_dec_pkg::SLTI,
      rv_dec_pkg::SLTIU, rv_dec_pkg::XORI, rv_dec_pkg::ORI, rv_dec_pkg::ANDI,
      rv_dec_pkg::SLLI, rv_dec_pkg::SRLI, rv_dec_pkg::SRAI,
      rv_dec_pkg::FENCE, rv_dec_pkg::FENCE_TSO,
      rv_dec_pkg::CSRRW, rv_dec_pkg::CSRRS, rv_dec_pkg::CSRRC:
        use_v = 3'b110;
      rv_dec_pkg::BEQ, rv_dec_pkg::BNE, rv_dec_pkg::BLT, rv_dec_pkg::BGE,
      rv_dec_pkg::BLTU, rv_dec_pkg::BGEU, rv_dec_pkg::SB, rv_dec_pkg::SH, rv_dec_pkg::SW:
        use_v = 3'b011;
      rv_dec_pkg::ADD, rv_dec_pkg::SUB, rv_dec_pkg::SLL, rv_dec_pkg::SLT,
      rv_dec_pkg::SLTU, rv_dec_pkg::XOR, rv_dec_pkg::SRL, rv_dec_pkg::SRA,
      rv_dec_pkg::OR, rv_dec_pkg::AND, rv_dec_pkg::MUL, rv_dec_pkg::MULH,
      rv_dec_pkg::MULHSU, rv_dec_pkg::MULHU, rv_dec_pkg::DIV, rv_dec_pkg::DIVU,
      rv_dec_pkg::REM, rv_dec_pkg::REMU:
        use_v = 3'b111;
      default: use_v = 3'b000;
    endcase

    case (f)
      rv_dec_pkg::LUI, rv_dec_pkg::AUIPC:
        imm = {w[31:12], 12'h000};
      rv_dec_pkg::JAL:
        imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      rv_dec_pkg::JALR, rv_dec_pkg::LB, rv_dec_pkg::LH, rv_dec_pkg::LW,
      rv_dec_pkg::LBU, rv_dec_pkg::LHU, rv_dec_pkg::ADDI, rv_dec_pkg::SLTI,
      rv_dec_pkg::SLTIU, rv_dec_pkg::XORI, rv_dec_pkg::ORI, rv_dec_pkg::ANDI,
      rv_dec_pkg::SLLI, rv_dec_pkg::SRLI, rv_dec_pkg::SRAI:
        imm = {{20{w[31]}}, w[31:20]};
      rv_dec_pkg::BEQ, rv_dec_pkg::BNE, rv_dec_pkg::BLT, rv_dec_pkg::BGE,
      rv_dec_pkg::BLTU, rv_dec_pkg::BGEU:
        imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      rv_dec_pkg::SB, rv_dec_pkg::SH, rv_dec_pkg::SW:
        imm = {{20{w[31]}}, w[31:25], w[11:7]};
      rv_dec_pkg::CSRRWI, rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI:
        imm = {27'd0, w[19:15]};
      default: imm = 32'd0;
    endcase

    rd  = use_v[2] ? w[11:7] : 5'd0;
    rs1 = use_v[1] ? w[19:15] : 5'd0;
    rs2 = use_v[0] ? w[24:20] : 5'd0;
    csr = (f inside {rv_dec_pkg::CSRRW, rv_dec_pkg::CSRRS, rv_dec_pkg::CSRRC,
                     rv_dec_pkg::CSRRWI, rv_dec_pkg::CSRRSI, rv_dec_pkg::CSRRCI})
          ? w[31:20] : 12'd0;
  endfunction

  function automatic logic [31:0] random_word();
    int          sel;
    int          k;
    logic [31:0] r;
    sel = int'($urandom % 8);
    r   = $urandom;
    if (sel < 5) begin
      // random fields under a kept instruction's pattern
      k = int'($urandom % rv_dec_pkg::N_FUNC);
      return (r & ~rv_dec_pkg::MASK_TBL[k]) | rv_dec_pkg::MATCH_TBL[k];
    end else if (sel < 7) begin
      k = int'($urandom % 8);
      return {r[31:7], ODD_OPS[k]};
    end else begin
      return r;
    end
  endfunction

  // oldest queued word was registered at the last rising edge
  task automatic check_oldest();
    logic        v;
    logic [31:0] w;
    v = valid_q.pop_front();
    w = word_q.pop_front();
    if (v)
      ref_decode(w, exp_func, exp_rd, exp_rs1, exp_rs2, exp_imm, exp_csr);
    check_value("valid_o", {31'd0, out_valid}, {31'd0, v});
    check_value("func_o", {25'd0, out_func}, {25'd0, exp_func});
    check_value("rd_o", {27'd0, out_rd}, {27'd0, exp_rd});
    check_value("rs1_o", {27'd0, out_rs1}, {27'd0, exp_rs1});
    check_value("rs2_o", {27'd0, out_rs2}, {27'd0, exp_rs2});
    check_value("imm_o", out_imm, exp_imm);
    check_value("csr_o", {20'd0, out_csr}, {20'd0, exp_csr});
  endtask

  task automatic drive_word(input logic v, input logic [31:0] w);
    @(posedge clk);
    in_valid <= v;
    in_code  <= w;
    valid_q.push_back(v);
    word_q.push_back(w);
    @(negedge clk);
    if (valid_q.size() > 1)
      check_oldest();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before all words were checked");
    $display("Test failed");
    $fatal(1, "timeout");
  end

  initial begin
    logic v;
    void'($urandom(SEED));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_code  = 32'd0;
    // reset values of the output fields
    exp_func = rv_dec_pkg::func_e'(7'h00);
    exp_rd   = 5'd0;
    exp_rs1  = 5'd0;
    exp_rs2  = 5'd0;
    exp_imm  = 32'd0;
    exp_csr  = 12'd0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    valid_q.push_back(1'b0);
    word_q.push_back(32'd0);
    repeat (3) drive_word(1'b0, 32'd0);
    for (int n = 0; n < N_WORDS; n++) begin
      v = ($urandom % 4) != 32'd0;
      drive_word(v, random_word());
    end
    drive_word(1'b0, 32'd0);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/rv_dec_pkg.sv
source/rv_instr_match.sv
source/rv_imm_extract.sv
source/rv_dec_combine.sv
source/rv_dec_top.sv
tb/tb_clkgen.sv
tb/rv_dec_chk.sv
tb/rv_dec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module rv_dec_tb \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vrv_dec_tb > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"
